/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       ?= tb_vec_unit
FILELIST  ?= compile.f
OBJDIR    ?= obj_dir
PASS_MSG  := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o V$(TOP)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJDIR)

/* compile.f */
+incdir+test
rtl/vec_pkg.sv
rtl/vec_sequencer.sv
rtl/vec_lane.sv
rtl/vec_sldu.sv
rtl/vec_masku.sv
rtl/vec_unit.sv
test/tb_vec_unit.sv

/* rtl/vec_lane.sv */
// Vector lane datapath
`default_nettype none

module vec_lane import vec_pkg::*; #(
  parameter  int unsigned ElemsPerLane = 4,
  localparam int unsigned RowWidth     = row_width(ElemsPerLane)
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Control from the sequencer
  input  logic [RowWidth-1:0] row_i,
  input  vreg_t               vd_i,
  input  vreg_t               vs1_i,
  input  vreg_t               vs2_i,
  input  logic                we_i,
  input  alu_op_e             alu_op_i,
  input  wb_sel_e             wb_sel_i,
  // Writeback sources beside the ALU
  input  elem_t               scalar_i,
  input  elem_t               slide_i,
  // vs2 element toward the slide and mask units
  output elem_t               vs2_data_o
);

  //////////////////////////////////////////////////////////////////////////////
  // Register file slice
  //////////////////////////////////////////////////////////////////////////////

  // This lane's rows of every vector register
  elem_t vrf_q [NrVRegs][ElemsPerLane];

  elem_t vs1_data;
  elem_t vs2_data;
  elem_t alu_res;
  elem_t wb_data;

  // Combinational read of both sources at the current row
  assign vs1_data = vrf_q[vs1_i][row_i];
  assign vs2_data = vrf_q[vs2_i][row_i];

  assign vs2_data_o = vs2_data;

  //////////////////////////////////////////////////////////////////////////////
  // ALU and writeback
  //////////////////////////////////////////////////////////////////////////////

  // Subtraction follows the RVV order, vs2 minus vs1
  always_comb begin
    case (alu_op_i)
      ALU_ADD: alu_res = vs2_data + vs1_data;
      ALU_SUB: alu_res = vs2_data - vs1_data;
      ALU_AND: alu_res = vs2_data & vs1_data;
      default: alu_res = vs2_data + vs1_data;
    endcase
  end

  always_comb begin
    case (wb_sel_i)
      WB_ALU:    wb_data = alu_res;
      WB_SLIDE:  wb_data = slide_i;
      WB_SCALAR: wb_data = scalar_i;
      default:   wb_data = alu_res;
    endcase
  end

  // Write lands at the end of the issuing cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int unsigned r = 0; r < NrVRegs; r++) begin
        for (int unsigned e = 0; e < ElemsPerLane; e++) begin
          vrf_q[r][e] <= '0;
        end
      end
    end else if (we_i) begin
      vrf_q[vd_i][row_i] <= wb_data;
    end
  end

endmodule : vec_lane

`default_nettype wire

/* rtl/vec_masku.sv */
// Mask popcount and scalar result
`default_nettype none

module vec_masku import vec_pkg::*; #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                start_i,
  input  logic                step_i,
  input  res_sel_e            res_sel_i,
  input  elem_t [NrLanes-1:0] vs2_row_i,
  output elem_t               result_o
);

  elem_t count_q;
  elem_t elem0_q;
  logic  first_q;
  elem_t row_ones;

  // Mask bits set in the current row
  always_comb begin
    row_ones = '0;
    for (int unsigned k = 0; k < NrLanes; k++) begin
      row_ones = row_ones + elem_t'(vs2_row_i[k][0]);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
      first_q <= 1'b0;
    end else if (start_i) begin
      count_q <= '0;
      first_q <= 1'b1;
    end else if (step_i) begin
      count_q <= count_q + row_ones;
      first_q <= 1'b0;
    end
  end

  // Element 0 sits in lane 0 of row 0
  always_ff @(posedge clk_i) begin
    if (step_i && first_q) begin
      elem0_q <= vs2_row_i[0];
    end
  end

  assign result_o = (res_sel_i == RES_ELEM0) ? elem0_q : count_q;

endmodule : vec_masku

`default_nettype wire

/* rtl/vec_pkg.sv */
// Vector unit shared types
`default_nettype none

package vec_pkg;

  // Element width, also used for the scalar operand and response
  localparam int unsigned ElemWidth = 16;
  // Architectural vector registers
  localparam int unsigned NrVRegs   = 8;

  typedef logic [ElemWidth-1:0]        elem_t;
  typedef logic [$clog2(NrVRegs)-1:0]  vreg_t;

  // Instruction opcodes
  typedef enum logic [2:0] {
    VADD,
    VSUB,
    VAND,
    VMV_V_X,
    VSLIDE1UP,
    VCPOP,
    VMV_X_S
  } vec_op_e;

  // Lane ALU function
  typedef enum logic [1:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND
  } alu_op_e;

  // Lane writeback source
  typedef enum logic [1:0] {
    WB_ALU,
    WB_SLIDE,
    WB_SCALAR
  } wb_sel_e;

  // Mask unit result choice
  typedef enum logic {
    RES_COUNT,
    RES_ELEM0
  } res_sel_e;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    RESP
  } seq_state_e;

  // Row index width, at least one bit
  function automatic int unsigned row_width(int unsigned elems_per_lane);
    return (elems_per_lane > 1) ? $clog2(elems_per_lane) : 1;
  endfunction

endpackage : vec_pkg

`default_nettype wire

/* rtl/vec_sequencer.sv */
// Vector instruction sequencer
`default_nettype none

module vec_sequencer import vec_pkg::*; #(
  parameter  int unsigned ElemsPerLane = 4,
  localparam int unsigned RowWidth     = row_width(ElemsPerLane)
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Instruction path
  input  logic                insn_valid_i,
  input  vec_op_e             insn_op_i,
  input  vreg_t               insn_vd_i,
  input  vreg_t               insn_vs1_i,
  input  vreg_t               insn_vs2_i,
  input  elem_t               insn_scalar_i,
  output logic                insn_ready_o,
  output logic                resp_valid_o,
  // Lane control
  output logic [RowWidth-1:0] row_o,
  output vreg_t               vd_o,
  output vreg_t               vs1_o,
  output vreg_t               vs2_o,
  output logic                we_o,
  output alu_op_e             alu_op_o,
  output wb_sel_e             wb_sel_o,
  // Slide and mask unit control
  output elem_t               scalar_o,
  output logic                start_o,
  output logic                step_o,
  output res_sel_e            res_sel_o
);

  seq_state_e          state_q, state_d;
  logic [RowWidth-1:0] row_q;
  logic                accept;
  logic                last_row;

  // Decoded control, captured at acceptance
  alu_op_e  alu_op_d, alu_op_q;
  wb_sel_e  wb_sel_d, wb_sel_q;
  res_sel_e res_sel_d, res_sel_q;
  logic     we_d, we_q;

  vreg_t vd_q;
  vreg_t vs1_q;
  vreg_t vs2_q;
  elem_t scalar_q;

  assign insn_ready_o = (state_q == IDLE);
  assign accept       = insn_valid_i && insn_ready_o;
  assign last_row     = (row_q == RowWidth'(ElemsPerLane - 1));

  always_comb begin
    alu_op_d  = ALU_ADD;
    wb_sel_d  = WB_ALU;
    res_sel_d = RES_COUNT;
    we_d      = 1'b1;
    case (insn_op_i)
      VADD:      alu_op_d = ALU_ADD;
      VSUB:      alu_op_d = ALU_SUB;
      VAND:      alu_op_d = ALU_AND;
      VMV_V_X:   wb_sel_d = WB_SCALAR;
      VSLIDE1UP: wb_sel_d = WB_SLIDE;
      VCPOP:     we_d     = 1'b0;
      VMV_X_S: begin
        we_d      = 1'b0;
        res_sel_d = RES_ELEM0;
      end
      default:   we_d     = 1'b0;
    endcase
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (accept) state_d = RUN;
      RUN:     if (last_row) state_d = RESP;
      RESP:    state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= IDLE;
      row_q     <= '0;
      alu_op_q  <= ALU_ADD;
      wb_sel_q  <= WB_ALU;
      res_sel_q <= RES_COUNT;
      we_q      <= 1'b0;
    end else begin
      state_q <= state_d;
      // One row per RUN cycle, back to zero after the last
      if (state_q == RUN) begin
        row_q <= last_row ? '0 : row_q + RowWidth'(1);
      end
      if (accept) begin
        alu_op_q  <= alu_op_d;
        wb_sel_q  <= wb_sel_d;
        res_sel_q <= res_sel_d;
        we_q      <= we_d;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      vd_q     <= insn_vd_i;
      vs1_q    <= insn_vs1_i;
      vs2_q    <= insn_vs2_i;
      scalar_q <= insn_scalar_i;
    end
  end

  assign row_o        = row_q;
  assign vd_o         = vd_q;
  assign vs1_o        = vs1_q;
  assign vs2_o        = vs2_q;
  assign alu_op_o     = alu_op_q;
  assign wb_sel_o     = wb_sel_q;
  assign res_sel_o    = res_sel_q;
  assign we_o         = (state_q == RUN) && we_q;
  assign step_o       = (state_q == RUN);
  assign start_o      = accept;
  assign resp_valid_o = (state_q == RESP);

  // Forwarded while idle so the slide carry sees the new scalar at acceptance
  assign scalar_o = (state_q == IDLE) ? insn_scalar_i : scalar_q;

endmodule : vec_sequencer

`default_nettype wire

/* rtl/vec_sldu.sv */
// Slide-up by one element
`default_nettype none

module vec_sldu import vec_pkg::*; #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                start_i,
  input  logic                step_i,
  input  elem_t               scalar_i,
  input  elem_t [NrLanes-1:0] vs2_row_i,
  output elem_t [NrLanes-1:0] slide_row_o
);

  // Element crossing into lane 0 from the previous row
  elem_t carry_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      carry_q <= '0;
    end else if (start_i) begin
      // Scalar becomes element 0 of the result
      carry_q <= scalar_i;
    end else if (step_i) begin
      carry_q <= vs2_row_i[NrLanes-1];
    end
  end

  // Each lane takes its left neighbour, lane 0 takes the carry
  always_comb begin
    slide_row_o[0] = carry_q;
    for (int unsigned k = 1; k < NrLanes; k++) begin
      slide_row_o[k] = vs2_row_i[k-1];
    end
  end

endmodule : vec_sldu

`default_nettype wire

/* rtl/vec_unit.sv */
// Lane-based vector unit top
`default_nettype none

module vec_unit import vec_pkg::*; #(
  parameter int unsigned NrLanes      = 4,
  parameter int unsigned ElemsPerLane = 4
) (
  input  logic    clk_i,
  input  logic    rst_n_i,
  // Instruction path
  input  logic    insn_valid_i,
  input  vec_op_e insn_op_i,
  input  vreg_t   insn_vd_i,
  input  vreg_t   insn_vs1_i,
  input  vreg_t   insn_vs2_i,
  input  elem_t   insn_scalar_i,
  output logic    insn_ready_o,
  // Scalar response
  output logic    resp_valid_o,
  output elem_t   resp_o
);

  localparam int unsigned RowWidth = row_width(ElemsPerLane);

  //////////////////////////////////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////////////////////////////////

  logic [RowWidth-1:0] row;
  vreg_t               vd;
  vreg_t               vs1;
  vreg_t               vs2;
  logic                we;
  alu_op_e             alu_op;
  wb_sel_e             wb_sel;
  elem_t               scalar;
  logic                start;
  logic                step;
  res_sel_e            res_sel;

  vec_sequencer #(
    .ElemsPerLane(ElemsPerLane)
  ) i_sequencer (
    .clk_i        (clk_i        ),
    .rst_n_i      (rst_n_i      ),
    .insn_valid_i (insn_valid_i ),
    .insn_op_i    (insn_op_i    ),
    .insn_vd_i    (insn_vd_i    ),
    .insn_vs1_i   (insn_vs1_i   ),
    .insn_vs2_i   (insn_vs2_i   ),
    .insn_scalar_i(insn_scalar_i),
    .insn_ready_o (insn_ready_o ),
    .resp_valid_o (resp_valid_o ),
    .row_o        (row          ),
    .vd_o         (vd           ),
    .vs1_o        (vs1          ),
    .vs2_o        (vs2          ),
    .we_o         (we           ),
    .alu_op_o     (alu_op       ),
    .wb_sel_o     (wb_sel       ),
    .scalar_o     (scalar       ),
    .start_o      (start        ),
    .step_o       (step         ),
    .res_sel_o    (res_sel      )
  );

  //////////////////////////////////////////////////////////////////////////////
  // Lanes
  //////////////////////////////////////////////////////////////////////////////

  // Per-lane operands toward the slide and mask units
  elem_t [NrLanes-1:0] vs2_row;
  elem_t [NrLanes-1:0] slide_row;

  for (genvar lane = 0; lane < NrLanes; lane++) begin : gen_lanes
    vec_lane #(
      .ElemsPerLane(ElemsPerLane)
    ) i_lane (
      .clk_i     (clk_i         ),
      .rst_n_i   (rst_n_i       ),
      .row_i     (row           ),
      .vd_i      (vd            ),
      .vs1_i     (vs1           ),
      .vs2_i     (vs2           ),
      .we_i      (we            ),
      .alu_op_i  (alu_op        ),
      .wb_sel_i  (wb_sel        ),
      .scalar_i  (scalar        ),
      .slide_i   (slide_row[lane]),
      .vs2_data_o(vs2_row[lane] )
    );
  end : gen_lanes

  //////////////////////////////////////////////////////////////////////////////
  // Slide and mask units
  //////////////////////////////////////////////////////////////////////////////

  vec_sldu #(
    .NrLanes(NrLanes)
  ) i_sldu (
    .clk_i      (clk_i    ),
    .rst_n_i    (rst_n_i  ),
    .start_i    (start    ),
    .step_i     (step     ),
    .scalar_i   (scalar   ),
    .vs2_row_i  (vs2_row  ),
    .slide_row_o(slide_row)
  );

  vec_masku #(
    .NrLanes(NrLanes)
  ) i_masku (
    .clk_i    (clk_i  ),
    .rst_n_i  (rst_n_i),
    .start_i  (start  ),
    .step_i   (step   ),
    .res_sel_i(res_sel),
    .vs2_row_i(vs2_row),
    .result_o (resp_o )
  );

endmodule : vec_unit

`default_nettype wire

/* test/tb_vec_model.svh */
// Vector register file model
`ifndef TB_VEC_MODEL_SVH
`define TB_VEC_MODEL_SVH

// Whole vector registers, element i at index i
elem_t       model_vrf [NrVRegs][NrElems];
logic [31:0] lcg_state;

// Scalar generator, upper bits of a 32-bit LCG
function automatic elem_t lcg_next();
  lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
  return lcg_state[30:15];
endfunction

task automatic model_reset();
  lcg_state = 32'd11822;
  for (int unsigned r = 0; r < NrVRegs; r++) begin
    for (int unsigned e = 0; e < NrElems; e++) begin
      model_vrf[r][e] = '0;
    end
  end
endtask

// Applies one instruction to the model and gives the scalar response
function automatic elem_t model_apply(vec_op_e op, vreg_t vd, vreg_t vs1, vreg_t vs2,
                                      elem_t scalar);
  elem_t src [NrElems];
  elem_t result;
  result = '0;
  // Copy first so vd may alias vs2
  for (int unsigned i = 0; i < NrElems; i++) begin
    src[i] = model_vrf[vs2][i];
  end
  case (op)
    VADD: begin
      for (int unsigned i = 0; i < NrElems; i++) begin
        model_vrf[vd][i] = src[i] + model_vrf[vs1][i];
      end
    end
    VSUB: begin
      for (int unsigned i = 0; i < NrElems; i++) begin
        model_vrf[vd][i] = src[i] - model_vrf[vs1][i];
      end
    end
    VAND: begin
      for (int unsigned i = 0; i < NrElems; i++) begin
        model_vrf[vd][i] = src[i] & model_vrf[vs1][i];
      end
    end
    VMV_V_X: begin
      for (int unsigned i = 0; i < NrElems; i++) begin
        model_vrf[vd][i] = scalar;
      end
    end
    VSLIDE1UP: begin
      model_vrf[vd][0] = scalar;
      for (int unsigned i = 1; i < NrElems; i++) begin
        model_vrf[vd][i] = src[i-1];
      end
    end
    VCPOP: begin
      for (int unsigned i = 0; i < NrElems; i++) begin
        result = result + elem_t'(src[i][0]);
      end
    end
    VMV_X_S: result = src[0];
    default: result = '0;
  endcase
  return result;
endfunction

`endif

/* test/tb_vec_unit.sv */
// Vector unit testbench
`default_nettype none

module tb_vec_unit import vec_pkg::*;;

  localparam int unsigned NrLanes      = 4;
  localparam int unsigned ElemsPerLane = 4;
  localparam int unsigned NrElems      = NrLanes * ElemsPerLane;
  localparam int unsigned NrRows       = 25;
  localparam int unsigned RespLatency  = ElemsPerLane + 1;
  localparam int unsigned RespLimit    = RespLatency + 8;
  localparam int unsigned CycleLimit   = NrRows * (ElemsPerLane + 2) + 100;

  logic    clk;
  logic    rst_n;
  logic    insn_valid;
  vec_op_e insn_op;
  vreg_t   insn_vd;
  vreg_t   insn_vs1;
  vreg_t   insn_vs2;
  elem_t   insn_scalar;
  logic    insn_ready;
  logic    resp_valid;
  elem_t   resp;

  // Instruction table
  vec_op_e     tab_op     [NrRows];
  vreg_t       tab_vd     [NrRows];
  vreg_t       tab_vs1    [NrRows];
  vreg_t       tab_vs2    [NrRows];
  elem_t       tab_scalar [NrRows];
  bit          tab_check  [NrRows];
  int unsigned fill_idx;

  int unsigned error_count;
  int unsigned rows_passed;
  int unsigned rows_failed;
  int unsigned accepted;

  `include "tb_vec_model.svh"

  vec_unit #(
    .NrLanes     (NrLanes     ),
    .ElemsPerLane(ElemsPerLane)
  ) dut (
    .clk_i        (clk        ),
    .rst_n_i      (rst_n      ),
    .insn_valid_i (insn_valid ),
    .insn_op_i    (insn_op    ),
    .insn_vd_i    (insn_vd    ),
    .insn_vs1_i   (insn_vs1   ),
    .insn_vs2_i   (insn_vs2   ),
    .insn_scalar_i(insn_scalar),
    .insn_ready_o (insn_ready ),
    .resp_valid_o (resp_valid ),
    .resp_o       (resp       )
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Table setup and driving
  ////////////////////////////////////////////////////////////////////////////

  task automatic add_row(input vec_op_e op, input vreg_t vd, input vreg_t vs1,
                         input vreg_t vs2, input bit check);
    tab_op[fill_idx]     = op;
    tab_vd[fill_idx]     = vd;
    tab_vs1[fill_idx]    = vs1;
    tab_vs2[fill_idx]    = vs2;
    tab_scalar[fill_idx] = lcg_next();
    tab_check[fill_idx]  = check;
    fill_idx++;
  endtask

  task automatic build_table();
    fill_idx = 0;
    // Splats read back by element 0 and mask count
    add_row(VMV_V_X,   3'd1, 3'd0, 3'd0, 1'b0);
    add_row(VMV_X_S,   3'd0, 3'd0, 3'd1, 1'b1);
    add_row(VCPOP,     3'd0, 3'd0, 3'd1, 1'b1);
    add_row(VMV_V_X,   3'd2, 3'd0, 3'd0, 1'b0);
    add_row(VCPOP,     3'd0, 3'd0, 3'd2, 1'b1);
    // Element-wise arithmetic
    add_row(VADD,      3'd3, 3'd1, 3'd2, 1'b0);
    add_row(VMV_X_S,   3'd0, 3'd0, 3'd3, 1'b1);
    add_row(VCPOP,     3'd0, 3'd0, 3'd3, 1'b1);
    add_row(VSUB,      3'd4, 3'd1, 3'd2, 1'b0);
    add_row(VMV_X_S,   3'd0, 3'd0, 3'd4, 1'b1);
    add_row(VAND,      3'd5, 3'd1, 3'd2, 1'b0);
    add_row(VMV_X_S,   3'd0, 3'd0, 3'd5, 1'b1);
    add_row(VCPOP,     3'd0, 3'd0, 3'd5, 1'b1);
    // Slide chains, some in place
    add_row(VSLIDE1UP, 3'd6, 3'd0, 3'd0, 1'b0);
    add_row(VSLIDE1UP, 3'd6, 3'd0, 3'd6, 1'b0);
    add_row(VSLIDE1UP, 3'd6, 3'd0, 3'd6, 1'b0);
    add_row(VMV_X_S,   3'd0, 3'd0, 3'd6, 1'b1);
    add_row(VCPOP,     3'd0, 3'd0, 3'd6, 1'b1);
    add_row(VSLIDE1UP, 3'd7, 3'd0, 3'd3, 1'b0);
    add_row(VSLIDE1UP, 3'd7, 3'd0, 3'd7, 1'b0);
    add_row(VMV_X_S,   3'd0, 3'd0, 3'd7, 1'b1);
    add_row(VCPOP,     3'd0, 3'd0, 3'd7, 1'b1);
    add_row(VADD,      3'd0, 3'd6, 3'd7, 1'b0);
    add_row(VCPOP,     3'd0, 3'd0, 3'd0, 1'b1);
    add_row(VMV_X_S,   3'd0, 3'd0, 3'd0, 1'b1);
  endtask

  task automatic drive_row(input int unsigned idx);
    insn_valid  <= 1'b1;
    insn_op     <= tab_op[idx];
    insn_vd     <= tab_vd[idx];
    insn_vs1    <= tab_vs1[idx];
    insn_vs2    <= tab_vs2[idx];
    insn_scalar <= tab_scalar[idx];
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Apply loop and checks
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main
    int unsigned wait_cycles;
    bit          row_ok;
    elem_t       expected;
    rst_n       = 1'b0;
    insn_valid  = 1'b0;
    insn_op     = VADD;
    insn_vd     = '0;
    insn_vs1    = '0;
    insn_vs2    = '0;
    insn_scalar = '0;
    error_count = 0;
    rows_passed = 0;
    rows_failed = 0;
    model_reset();
    build_table();

    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    if (insn_ready !== 1'b1) begin
      $display("Error: insn_ready_o after reset is %h, expected 1", insn_ready);
      error_count++;
    end
    if (resp_valid !== 1'b0) begin
      $display("Error: resp_valid_o after reset is %h, expected 0", resp_valid);
      error_count++;
    end

    // Valid stays high from one row to the next
    drive_row(0);
    for (int unsigned i = 0; i < NrRows; i++) begin
      row_ok = 1'b1;
      do @(posedge clk); while (insn_ready !== 1'b1);
      if (i + 1 < NrRows) begin
        drive_row(i + 1);
      end else begin
        insn_valid <= 1'b0;
      end
      expected = model_apply(tab_op[i], tab_vd[i], tab_vs1[i], tab_vs2[i], tab_scalar[i]);

      // Busy until the response strobe
      wait_cycles = 0;
      do begin
        @(posedge clk);
        wait_cycles++;
        if (insn_ready !== 1'b0) begin
          $display("Error: row %0d insn_ready_o is %h, expected 0", i, insn_ready);
          row_ok = 1'b0;
        end
      end while (resp_valid !== 1'b1 && wait_cycles < RespLimit);

      if (resp_valid !== 1'b1) begin
        $display("Row %0d got no response within %0d cycles", i, RespLimit);
        row_ok = 1'b0;
      end else if (wait_cycles != RespLatency) begin
        $display("Row %0d response came %0d cycles after acceptance instead of %0d",
                 i, wait_cycles, RespLatency);
        row_ok = 1'b0;
      end
      if (resp_valid === 1'b1 && tab_check[i] && resp !== expected) begin
        $display("Error: row %0d resp_o is %h, expected %h", i, resp, expected);
        row_ok = 1'b0;
      end

      if (row_ok) begin
        rows_passed++;
      end else begin
        rows_failed++;
        error_count++;
      end
      $display("Row %0d %s vd %0d vs1 %0d vs2 %0d scalar %h: %s", i, tab_op[i].name(),
               tab_vd[i], tab_vs1[i], tab_vs2[i], tab_scalar[i], row_ok ? "ok" : "bad");
    end

    // Nothing left in flight once the table is done
    repeat (ElemsPerLane + 2) begin
      @(posedge clk);
      if (resp_valid !== 1'b0) begin
        $display("Error: resp_valid_o is %h after the last row, expected 0", resp_valid);
        error_count++;
      end
    end

    $display("Rows %0d, accepted %0d, passed %0d, failed %0d, errors %0d",
             NrRows, accepted, rows_passed, rows_failed, error_count);
    if (error_count == 0 && accepted == NrRows) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Handshakes seen at the DUT boundary
  always @(posedge clk) begin
    if (!rst_n) begin
      accepted <= 0;
    end else if (insn_valid === 1'b1 && insn_ready === 1'b1) begin
      accepted <= accepted + 1;
    end
  end

  // Cycle limit for a stuck handshake
  initial begin : watchdog
    int unsigned cycles;
    cycles = 0;
    while (cycles < CycleLimit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Run stopped at the cycle limit of %0d with rows still pending", CycleLimit);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule : tb_vec_unit

`default_nettype wire
